// ==== filelist.f ====
huff_tbl_pkg.sv
fifo_ctrl.sv
sched_fifo.sv
dec_tables.sv
sym_lookup.sv
huff_tbl_top.sv
tb_huff_tbl.sv

// ==== Bender.yml ====
package:
  name: huff_tbl

sources:
  - huff_tbl_pkg.sv
  - fifo_ctrl.sv
  - sched_fifo.sv
  - dec_tables.sv
  - sym_lookup.sv
  - huff_tbl_top.sv
  - target: test
    files:
      - tb_huff_tbl.sv

// ==== tb_huff_tbl.sv ====
`timescale 1ns/100ps

module tb_huff_tbl;

   localparam int max_bits   = huff_tbl_pkg::max_bits;
   // per block: two tables of writes plus hits and directed misses
   localparam int blk_cycles = 4 * (max_bits + huff_tbl_pkg::n_ll_syms)
                               + 2 * huff_tbl_pkg::n_ll_syms;
   localparam int max_cycles = 16 + 3 * blk_cycles + 64;

   logic clk, rst_n, tbl_wen, done_valid, sob_used, eob_used, sched_ren, lookup_valid;
   logic busy, sob_avail, rsp_valid, blk_error_cur;
   logic [1:0] slt_wen;
   huff_tbl_pkg::tbl_wr_t           tbl_wr;
   huff_tbl_pkg::slt_wr_t [1:0]     slt_wr;
   huff_tbl_pkg::blk_done_t         blk_done;
   huff_tbl_pkg::sched_t            sched_rdata;
   huff_tbl_pkg::lookup_req_t       lookup_req;
   huff_tbl_pkg::lookup_rsp_t       lookup_rsp;
   huff_tbl_pkg::blk_fmt_e          blk_fmt_cur;

   // reference model, indexed [bank][table][len][code]
   bit       hit_m [2][2][16][256];
   bit [4:0] sym_m [2][2][16][256];
   int       n_m   [2][2][9];
   int       bct_m [2][2][9];
   huff_tbl_pkg::blk_fmt_e fmt_m [2];
   bit       err_m [2];
   bit       wr_bank, rd_bank, exp_busy, exp_sob, exp_miss, exp_err;
   int       held, cycles;
   huff_tbl_pkg::ll_sym_t  exp_sym;
   huff_tbl_pkg::blk_fmt_e exp_fmt;
   huff_tbl_pkg::sched_t   exp_head;
   huff_tbl_pkg::sched_t   sched_q [$];
   logic [31:0] rng_state = 32'he6c3;

   huff_tbl_top #(.slt_per_cycle(2)) DUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycles <= cycles + 1;

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   function automatic logic [31:0] xorshift();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   ////////////////////////////////////////
   // checks

   a_reset_idle : assert property (@(posedge clk) !rst_n |-> !busy && !sob_avail && !rsp_valid)
      else abort_run($sformatf("ERROR at %0t ns: outputs not idle in reset", $time));
   a_busy : assert property (@(posedge clk) disable iff (!rst_n) busy == $past(exp_busy))
      else abort_run($sformatf("ERROR at %0t ns: busy is %0b", $time, $sampled(busy)));
   a_sob : assert property (@(posedge clk) disable iff (!rst_n) sob_avail == $past(exp_sob))
      else abort_run($sformatf("ERROR at %0t ns: sob_avail is %0b", $time, $sampled(sob_avail)));
   a_rsp_idle : assert property (@(posedge clk) disable iff (!rst_n) !lookup_valid |=> !rsp_valid)
      else abort_run($sformatf("ERROR at %0t ns: rsp_valid without request", $time));
   a_lookup : assert property (@(posedge clk) disable iff (!rst_n)
      lookup_valid |=> rsp_valid && lookup_rsp.miss == $past(exp_miss)
                       && ($past(exp_miss) || lookup_rsp.sym == $past(exp_sym)))
      else abort_run($sformatf("ERROR at %0t ns: lookup gave miss %0b sym %0d", $time,
                               $sampled(lookup_rsp.miss), $sampled(lookup_rsp.sym)));
   a_attr : assert property (@(posedge clk) disable iff (!rst_n)
      lookup_valid |-> blk_fmt_cur == exp_fmt && blk_error_cur == exp_err)
      else abort_run($sformatf("ERROR at %0t ns: block attributes of wrong bank", $time));
   a_sched : assert property (@(posedge clk) disable iff (!rst_n)
      sched_ren |-> sched_rdata == exp_head)
      else abort_run($sformatf("ERROR at %0t ns: schedule head %h, expected %h", $time,
                               $sampled(sched_rdata), exp_head));

   ////////////////////////////////////////
   // parser and decoder actions

   // canonical code assignment, lengths 3..top each get min_cnt..max_cnt symbols
   task automatic build_table(input logic sel, input int top, input int min_cnt,
                              input int max_cnt);
      int code;
      int prev;
      int idx;
      int i;
      bit pair;
      bit [4:0] s;
      bit [4:0] syms [$];
      code = 0;
      prev = 0;
      idx  = 0;
      for (int l = 0; l < 16; l++) begin
         for (int c = 0; c < 256; c++) begin
            hit_m[wr_bank][sel][l][c] = 1'b0;
         end
      end
      for (int l = 1; l <= max_bits; l++) begin
         n_m[wr_bank][sel][l] = 0;
         if (l >= 3 && l <= top) begin
            n_m[wr_bank][sel][l] = min_cnt + int'(xorshift() % (max_cnt - min_cnt + 1));
         end
         code = (code + prev) << 1;
         if (n_m[wr_bank][sel][l] > 0) begin
            bct_m[wr_bank][sel][l] = code;   // old base stays for cleared lengths
            tbl_wr  = '{sel: sel, len: huff_tbl_pkg::len_t'(l), bct: huff_tbl_pkg::code_t'(code),
                        valid: 1'b1, sat: huff_tbl_pkg::ll_sym_t'(idx)};
            tbl_wen = 1'b1;
            step();
            tbl_wen = 1'b0;
         end
         for (int k = 0; k < n_m[wr_bank][sel][l]; k++) begin
            s = 5'(xorshift()) & (sel ? 5'd31 : 5'd15);
            hit_m[wr_bank][sel][l][code + k] = 1'b1;
            sym_m[wr_bank][sel][l][code + k] = s;
            syms.push_back(s);
         end
         idx  = idx + n_m[wr_bank][sel][l];
         prev = n_m[wr_bank][sel][l];
      end
      i = 0;
      while (i < syms.size()) begin
         pair      = (syms.size() - i >= 2) && ((xorshift() & 32'h1) != 0);
         slt_wr[0] = '{sel: sel, idx: huff_tbl_pkg::ll_sym_t'(i), sym: syms[i]};
         if (pair) slt_wr[1] = '{sel: sel, idx: huff_tbl_pkg::ll_sym_t'(i + 1), sym: syms[i + 1]};
         slt_wen = pair ? 2'b11 : 2'b01;   // both lanes now and then
         step();
         slt_wen = 2'b00;
         i = i + (pair ? 2 : 1);
      end
   endtask

   task automatic finish_block(input huff_tbl_pkg::blk_fmt_e fmt, input bit err);
      blk_done = '{fmt: fmt, min_ptr_len: 1'(xorshift()), min_mtf_len: 1'(xorshift()),
                   error: err, sched: 16'(xorshift())};
      sched_q.push_back(blk_done.sched);
      fmt_m[wr_bank] = fmt;
      err_m[wr_bank] = err;
      done_valid = 1'b1;
      held       = held + 1;
      exp_sob    = 1'b1;
      exp_busy   = (held == 2) || (sched_q.size() == 4);
      step();
      done_valid = 1'b0;
      wr_bank    = !wr_bank;
      sob_used   = 1'b1;   // decoder takes the credit
      exp_sob    = 1'b0;
      step();
      sob_used   = 1'b0;
   endtask

   task automatic release_bank();
      eob_used = 1'b1;
      held     = held - 1;
      exp_busy = (held == 2) || (sched_q.size() == 4);
      step();
      eob_used = 1'b0;
      rd_bank  = !rd_bank;
   endtask

   task automatic pop_sched();
      exp_head  = sched_q.pop_front();
      sched_ren = 1'b1;
      exp_busy  = (held == 2) || (sched_q.size() == 4);
      step();
      sched_ren = 1'b0;
   endtask

   task automatic lookup(input logic sel, input int len, input int code);
      exp_miss = !hit_m[rd_bank][sel][len][code];
      exp_sym  = sym_m[rd_bank][sel][len][code];
      exp_fmt  = fmt_m[rd_bank];
      exp_err  = err_m[rd_bank];
      lookup_req = '{sel: sel, len: huff_tbl_pkg::len_t'(len), code: huff_tbl_pkg::code_t'(code)};
      lookup_valid = 1'b1;
      step();
      lookup_valid = 1'b0;
   endtask

   // every code, cleared lengths at their stale base, below-base codes and index at count
   task automatic check_table(input logic sel);
      int last;
      int b;
      int n;
      last = 1;
      for (int l = 1; l <= max_bits; l++) begin
         b = bct_m[rd_bank][sel][l];
         n = n_m[rd_bank][sel][l];
         if (n == 0) begin
            lookup(sel, l, b);
         end else begin
            for (int k = 0; k < n; k++) begin
               lookup(sel, l, b + k);
            end
            if (b > 0) lookup(sel, l, b - 1);
            last = l;
         end
      end
      lookup(sel, last, bct_m[rd_bank][sel][last] + n_m[rd_bank][sel][last]);
      lookup(sel, 0, 0);
      lookup(sel, max_bits + 1, 0);
   endtask

   initial begin
      wait (cycles >= max_cycles);
      abort_run($sformatf("timeout: run still going after %0d cycles", max_cycles));
   end

   initial begin
      rst_n = 1'b0;
      cycles = 0;
      {tbl_wen, done_valid, sob_used, eob_used, sched_ren, lookup_valid} = '0;
      slt_wen = '0;
      tbl_wr = '0;
      slt_wr = '0;
      blk_done = '0;
      lookup_req = '0;
      repeat (16) @(posedge clk);
      #2 rst_n = 1'b1;
      // block A in bank 0
      build_table(1'b0, 8, 1, 2);
      build_table(1'b1, 8, 1, 3);
      finish_block(huff_tbl_pkg::fmt_huff, 1'b0);
      check_table(1'b0);
      check_table(1'b1);
      // block B in bank 1, both banks now held
      build_table(1'b0, 8, 1, 2);
      build_table(1'b1, 8, 1, 3);
      finish_block(huff_tbl_pkg::fmt_huff_mtf, 1'b1);
      release_bank();
      check_table(1'b0);
      check_table(1'b1);
      // block C back in bank 0 with fewer lengths but more symbols
      build_table(1'b0, 5, 3, 4);
      build_table(1'b1, 5, 4, 4);
      finish_block(huff_tbl_pkg::fmt_raw, 1'b0);
      release_bank();
      check_table(1'b0);
      check_table(1'b1);
      // block D without tables fills the schedule queue
      finish_block(huff_tbl_pkg::fmt_huff, 1'b1);
      release_bank();
      lookup(1'b0, 0, 0);
      repeat (4) pop_sched();
      step();
      step();
      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== huff_tbl_top.sv ====
`timescale 1ns/100ps

module huff_tbl_top #(
   parameter int slt_per_cycle = 2
) (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      tbl_wen,
   input  huff_tbl_pkg::tbl_wr_t                     tbl_wr,
   input  logic [slt_per_cycle-1:0]                  slt_wen,
   input  huff_tbl_pkg::slt_wr_t [slt_per_cycle-1:0] slt_wr,
   input  logic                                      done_valid,
   input  huff_tbl_pkg::blk_done_t                   blk_done,
   output logic                                      busy,
   input  logic                                      sob_used,
   input  logic                                      eob_used,
   output logic                                      sob_avail,
   input  logic                                      sched_ren,
   output huff_tbl_pkg::sched_t                      sched_rdata,
   input  logic                                      lookup_valid,
   input  huff_tbl_pkg::lookup_req_t                 lookup_req,
   output logic                                      rsp_valid,
   output huff_tbl_pkg::lookup_rsp_t                 lookup_rsp,
   output huff_tbl_pkg::blk_fmt_e                    blk_fmt_cur,
   output logic                                      blk_error_cur
);

   // bank buses, table store to lookup
   huff_tbl_pkg::code_t   [1:0][huff_tbl_pkg::max_bits:1]    ss_bct, ll_bct;
   huff_tbl_pkg::ss_sym_t [1:0][huff_tbl_pkg::max_bits:1]    ss_sat;
   huff_tbl_pkg::ll_sym_t [1:0][huff_tbl_pkg::max_bits:1]    ll_sat;
   logic                  [1:0][huff_tbl_pkg::max_bits:1]    ss_valid, ll_valid;
   huff_tbl_pkg::ss_sym_t [1:0][huff_tbl_pkg::n_ss_syms-1:0] ss_slt;
   huff_tbl_pkg::ll_sym_t [1:0][huff_tbl_pkg::n_ll_syms-1:0] ll_slt;
   huff_tbl_pkg::ss_cnt_t [1:0]                              ss_cnt;
   huff_tbl_pkg::ll_cnt_t [1:0]                              ll_cnt;
   huff_tbl_pkg::blk_fmt_e [1:0]                             blk_fmt;
   logic [1:0]                                               blk_error;

   dec_tables #(
      .slt_per_cycle (slt_per_cycle)
   ) u_tables (
      .*,
      .blk_min_ptr_len (),   // consumed by the LZ stage
      .blk_min_mtf_len ()
   );

   sym_lookup u_lookup (.*);

endmodule

// ==== sym_lookup.sv ====
`timescale 1ns/100ps

module sym_lookup (
   input  logic                                                     clk,
   input  logic                                                     rst_n,
   input  logic                                                     eob_used,
   input  logic                                                     lookup_valid,
   input  huff_tbl_pkg::lookup_req_t                                lookup_req,
   input  huff_tbl_pkg::code_t   [1:0][huff_tbl_pkg::max_bits:1]    ss_bct,
   input  huff_tbl_pkg::ss_sym_t [1:0][huff_tbl_pkg::max_bits:1]    ss_sat,
   input  logic                  [1:0][huff_tbl_pkg::max_bits:1]    ss_valid,
   input  huff_tbl_pkg::ss_sym_t [1:0][huff_tbl_pkg::n_ss_syms-1:0] ss_slt,
   input  huff_tbl_pkg::ss_cnt_t [1:0]                              ss_cnt,
   input  huff_tbl_pkg::code_t   [1:0][huff_tbl_pkg::max_bits:1]    ll_bct,
   input  huff_tbl_pkg::ll_sym_t [1:0][huff_tbl_pkg::max_bits:1]    ll_sat,
   input  logic                  [1:0][huff_tbl_pkg::max_bits:1]    ll_valid,
   input  huff_tbl_pkg::ll_sym_t [1:0][huff_tbl_pkg::n_ll_syms-1:0] ll_slt,
   input  huff_tbl_pkg::ll_cnt_t [1:0]                              ll_cnt,
   input  huff_tbl_pkg::blk_fmt_e [1:0]                             blk_fmt,
   input  logic [1:0]                                               blk_error,
   output logic                                                     rsp_valid,
   output huff_tbl_pkg::lookup_rsp_t                                lookup_rsp,
   output huff_tbl_pkg::blk_fmt_e                                   blk_fmt_cur,
   output logic                                                     blk_error_cur
);

   logic                  rd_bank;
   logic                  len_ok;
   logic                  vld;
   logic                  miss;
   logic [8:0]            idx;
   huff_tbl_pkg::len_t    li;
   huff_tbl_pkg::code_t   base;
   huff_tbl_pkg::ll_sym_t sat;
   huff_tbl_pkg::ll_cnt_t cnt;
   huff_tbl_pkg::ll_sym_t sym;

   always_comb begin
      len_ok = (lookup_req.len != '0) && (lookup_req.len <= huff_tbl_pkg::max_bits);
      li     = len_ok ? lookup_req.len : huff_tbl_pkg::len_t'(1);   // keep index in range
      if (lookup_req.sel) begin
         base = ll_bct[rd_bank][li];
         sat  = ll_sat[rd_bank][li];
         vld  = ll_valid[rd_bank][li];
         cnt  = ll_cnt[rd_bank];
      end else begin
         base = ss_bct[rd_bank][li];
         sat  = huff_tbl_pkg::ll_sym_t'(ss_sat[rd_bank][li]);
         vld  = ss_valid[rd_bank][li];
         cnt  = huff_tbl_pkg::ll_cnt_t'(ss_cnt[rd_bank]);
      end
      // canonical index: sat + code - bct
      idx  = 9'(sat) + 9'(lookup_req.code) - 9'(base);
      miss = !len_ok || !vld || (lookup_req.code < base) || (idx >= 9'(cnt));
      sym  = lookup_req.sel ? ll_slt[rd_bank][idx[4:0]] :
                              huff_tbl_pkg::ll_sym_t'(ss_slt[rd_bank][idx[3:0]]);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_bank   <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         if (eob_used) rd_bank <= !rd_bank;   // follow completion order
         rsp_valid <= lookup_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (lookup_valid) begin
         lookup_rsp.sym  <= sym;
         lookup_rsp.miss <= miss;
      end
   end

   assign blk_fmt_cur   = blk_fmt[rd_bank];
   assign blk_error_cur = blk_error[rd_bank];

endmodule

// ==== dec_tables.sv ====
`timescale 1ns/100ps

module dec_tables #(
   parameter int slt_per_cycle = 2
) (
   input  logic                                                          clk,
   input  logic                                                          rst_n,
   // parser side
   input  logic                                                          tbl_wen,
   input  huff_tbl_pkg::tbl_wr_t                                         tbl_wr,
   input  logic [slt_per_cycle-1:0]                                      slt_wen,
   input  huff_tbl_pkg::slt_wr_t [slt_per_cycle-1:0]                     slt_wr,
   input  logic                                                          done_valid,
   input  huff_tbl_pkg::blk_done_t                                       blk_done,
   // decoder side
   input  logic                                                          sob_used,
   input  logic                                                          eob_used,
   input  logic                                                          sched_ren,
   output logic                                                          busy,
   output logic                                                          sob_avail,
   output huff_tbl_pkg::sched_t                                          sched_rdata,
   // both banks
   output huff_tbl_pkg::code_t   [1:0][huff_tbl_pkg::max_bits:1]         ss_bct,
   output huff_tbl_pkg::ss_sym_t [1:0][huff_tbl_pkg::max_bits:1]         ss_sat,
   output logic                  [1:0][huff_tbl_pkg::max_bits:1]         ss_valid,
   output huff_tbl_pkg::ss_sym_t [1:0][huff_tbl_pkg::n_ss_syms-1:0]      ss_slt,
   output huff_tbl_pkg::ss_cnt_t [1:0]                                   ss_cnt,
   output huff_tbl_pkg::code_t   [1:0][huff_tbl_pkg::max_bits:1]         ll_bct,
   output huff_tbl_pkg::ll_sym_t [1:0][huff_tbl_pkg::max_bits:1]         ll_sat,
   output logic                  [1:0][huff_tbl_pkg::max_bits:1]         ll_valid,
   output huff_tbl_pkg::ll_sym_t [1:0][huff_tbl_pkg::n_ll_syms-1:0]      ll_slt,
   output huff_tbl_pkg::ll_cnt_t [1:0]                                   ll_cnt,
   output huff_tbl_pkg::blk_fmt_e [1:0]                                  blk_fmt,
   output logic [1:0]                                                    blk_min_ptr_len,
   output logic [1:0]                                                    blk_min_mtf_len,
   output logic [1:0]                                                    blk_error
);

   logic wbank;   // parser write bank
   logic prs_full;
   logic dec_empty;
   logic sched_full;
   logic ss_tbl_first, ll_tbl_first;
   logic ss_slt_first, ll_slt_first;
   logic ss_tbl_we, ll_tbl_we;
   logic [slt_per_cycle-1:0] ss_lane, ll_lane;
   huff_tbl_pkg::ss_cnt_t ss_add;
   huff_tbl_pkg::ll_cnt_t ll_add;

   assign busy      = prs_full || sched_full;
   assign sob_avail = !dec_empty;
   assign ss_tbl_we = tbl_wen && !tbl_wr.sel;
   assign ll_tbl_we = tbl_wen && tbl_wr.sel;

   always_comb begin
      ss_add = '0;
      ll_add = '0;
      for (int i = 0; i < slt_per_cycle; i++) begin
         ss_lane[i] = slt_wen[i] && !slt_wr[i].sel;
         ll_lane[i] = slt_wen[i] && slt_wr[i].sel;
         if (ss_lane[i]) ss_add = ss_add + 1'b1;
         if (ll_lane[i]) ll_add = ll_add + 1'b1;
      end
   end

   ////////////////////////////////////////
   // first-write flags, valid and counts

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ss_tbl_first <= 1'b1;
         ll_tbl_first <= 1'b1;
         ss_slt_first <= 1'b1;
         ll_slt_first <= 1'b1;
      end else if (done_valid) begin   // rearm for next block
         ss_tbl_first <= 1'b1;
         ll_tbl_first <= 1'b1;
         ss_slt_first <= 1'b1;
         ll_slt_first <= 1'b1;
      end else begin
         if (ss_tbl_we) ss_tbl_first <= 1'b0;
         if (ll_tbl_we) ll_tbl_first <= 1'b0;
         if (|ss_lane) ss_slt_first <= 1'b0;
         if (|ll_lane) ll_slt_first <= 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ss_valid <= '0;
         ll_valid <= '0;
         ss_cnt   <= '0;
         ll_cnt   <= '0;
      end else begin
         if (ss_tbl_we) begin
            if (ss_tbl_first) ss_valid[wbank] <= '0;
            ss_valid[wbank][tbl_wr.len] <= tbl_wr.valid;   // bit write wins over clear
         end
         if (ll_tbl_we) begin
            if (ll_tbl_first) ll_valid[wbank] <= '0;
            ll_valid[wbank][tbl_wr.len] <= tbl_wr.valid;
         end
         if (|ss_lane) ss_cnt[wbank] <= (ss_slt_first ? '0 : ss_cnt[wbank]) + ss_add;
         if (|ll_lane) ll_cnt[wbank] <= (ll_slt_first ? '0 : ll_cnt[wbank]) + ll_add;
      end
   end

   ////////////////////////////////////////
   // table payload and block attributes

   always_ff @(posedge clk) begin
      if (ss_tbl_we) begin
         ss_bct[wbank][tbl_wr.len] <= tbl_wr.bct;
         ss_sat[wbank][tbl_wr.len] <= huff_tbl_pkg::ss_sym_t'(tbl_wr.sat);
      end
      if (ll_tbl_we) begin
         ll_bct[wbank][tbl_wr.len] <= tbl_wr.bct;
         ll_sat[wbank][tbl_wr.len] <= tbl_wr.sat;
      end
      for (int i = 0; i < slt_per_cycle; i++) begin
         if (ss_lane[i]) begin
            ss_slt[wbank][huff_tbl_pkg::ss_sym_t'(slt_wr[i].idx)] <=
               huff_tbl_pkg::ss_sym_t'(slt_wr[i].sym);
         end
         if (ll_lane[i]) ll_slt[wbank][slt_wr[i].idx] <= slt_wr[i].sym;
      end
      if (done_valid) begin
         blk_fmt[wbank]         <= blk_done.fmt;
         blk_min_ptr_len[wbank] <= blk_done.min_ptr_len;
         blk_min_mtf_len[wbank] <= blk_done.min_mtf_len;
         blk_error[wbank]       <= blk_done.error;
      end
   end

   ////////////////////////////////////////
   // bank credits and schedule queue

   fifo_ctrl #(.depth(2)) u_dec_credit (
      .clk (clk), .rst_n (rst_n),
      .wen (done_valid), .ren (sob_used),
      .empty (dec_empty), .full (), .wptr (), .rptr ()
   );

   fifo_ctrl #(.depth(2)) u_prs_credit (
      .clk (clk), .rst_n (rst_n),
      .wen (done_valid), .ren (eob_used),   // eob frees oldest bank
      .empty (), .full (prs_full), .wptr (wbank), .rptr ()
   );

   sched_fifo #(.depth(4)) u_sched (
      .clk (clk), .rst_n (rst_n),
      .wen (done_valid), .ren (sched_ren),
      .wdata (blk_done.sched), .rdata (sched_rdata), .full (sched_full)
   );

   a_no_write_busy : assert property (
      @(posedge clk) disable iff (!rst_n)
      busy |-> !(done_valid || tbl_wen || (|slt_wen))
   ) else $error("parser write while busy");

endmodule

// ==== sched_fifo.sv ====
`timescale 1ns/100ps

module sched_fifo #(
   parameter int depth = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                wen,
   input  logic                ren,
   input  huff_tbl_pkg::sched_t wdata,
   output huff_tbl_pkg::sched_t rdata,
   output logic                full
);

   logic [$clog2(depth)-1:0] wptr;
   logic [$clog2(depth)-1:0] rptr;

   huff_tbl_pkg::sched_t mem [depth];

   fifo_ctrl #(
      .depth (depth)
   ) u_ctrl (
      .clk   (clk),
      .rst_n (rst_n),
      .wen   (wen),
      .ren   (ren),
      .empty (),
      .full  (full),
      .wptr  (wptr),
      .rptr  (rptr)
   );

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[wptr] <= wdata;
      end
   end

   assign rdata = mem[rptr];   // head entry

endmodule

// ==== fifo_ctrl.sv ====
`timescale 1ns/100ps

module fifo_ctrl #(
   parameter int depth = 2
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     wen,
   input  logic                     ren,
   output logic                     empty,
   output logic                     full,
   output logic [$clog2(depth)-1:0] wptr,
   output logic [$clog2(depth)-1:0] rptr
);

   localparam int ptr_w = $clog2(depth);
   localparam int cnt_w = $clog2(depth + 1);

   logic [cnt_w-1:0] count;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (wen) begin
            wptr <= (wptr == ptr_w'(depth - 1)) ? '0 : wptr + 1'b1;
         end
         if (ren) begin
            rptr <= (rptr == ptr_w'(depth - 1)) ? '0 : rptr + 1'b1;
         end
         count <= count + cnt_w'(wen) - cnt_w'(ren);   // net occupancy change
      end
   end

   assign empty = (count == '0);
   assign full  = (count == cnt_w'(depth));

   ////////////////////////////////////////
   // overflow and underflow

   a_no_overflow : assert property (
      @(posedge clk) disable iff (!rst_n)
      full |-> !(wen && !ren)
   ) else $error("fifo_ctrl overflow");

   a_no_underflow : assert property (
      @(posedge clk) disable iff (!rst_n)
      ren |-> !empty
   ) else $error("fifo_ctrl underflow");

endmodule

// ==== huff_tbl_pkg.sv ====
package huff_tbl_pkg;

   localparam int max_bits  = 8;
   localparam int n_ss_syms = 16;
   localparam int n_ll_syms = 32;

   typedef logic [3:0]  len_t;
   typedef logic [7:0]  code_t;
   typedef logic [3:0]  ss_sym_t;
   typedef logic [4:0]  ll_sym_t;
   typedef logic [4:0]  ss_cnt_t;   // 0..16
   typedef logic [5:0]  ll_cnt_t;   // 0..32
   typedef logic [15:0] sched_t;

   typedef enum logic [1:0] {
      fmt_raw,
      fmt_huff,
      fmt_huff_mtf
   } blk_fmt_e;

   typedef struct packed {
      logic    sel;    // 0 ss, 1 ll
      len_t    len;
      code_t   bct;
      logic    valid;
      ll_sym_t sat;
   } tbl_wr_t;

   typedef struct packed {
      logic    sel;
      ll_sym_t idx;
      ll_sym_t sym;
   } slt_wr_t;

   typedef struct packed {
      blk_fmt_e fmt;
      logic     min_ptr_len;
      logic     min_mtf_len;
      logic     error;
      sched_t   sched;
   } blk_done_t;

   typedef struct packed {
      logic  sel;
      len_t  len;
      code_t code;
   } lookup_req_t;

   typedef struct packed {
      ll_sym_t sym;
      logic    miss;
   } lookup_rsp_t;

endpackage
